/* consul_pkg.sv */
package consul_pkg;

    // Settle periods in clock cycles
    localparam int unsigned PERIOD_SYMBOL = 5;    // Ordinary character
    localparam int unsigned PERIOD_COLOR  = 12;   // Case-shift code
    localparam int unsigned PERIOD_NL     = 500;  // Carriage return
    localparam int unsigned CNT_W         = $clog2(PERIOD_NL + 1);

    // Service codes
    localparam logic [6:0] CODE_CR         = 7'h0D;
    localparam logic [5:0] CODE_SHIFT_BASE = 6'b000111;  // LSB appended as target shift

    // Print sequencer state encoding
    localparam int unsigned SEQ_W         = 2;
    localparam logic [1:0]  SEQ_IDLE      = 2'd0;
    localparam logic [1:0]  SEQ_WAIT      = 2'd1;
    localparam logic [1:0]  SEQ_SET_CODE  = 2'd2;
    localparam logic [1:0]  SEQ_HOLD_SYNC = 2'd3;

    // Relay input lines, top to bottom
    typedef struct packed {
        logic       cin_ready;              // Key code present
        logic       top_symbol_correction;
        logic       red_print;
        logic       coacq;
        logic       high_reg;               // Current shift register
        logic       is_moving;              // Carriage busy
        logic       block_print;
        logic       need_nl;                // Machine wants a new line
        logic [7:0] kb_code;
    } consul_status_t;

    // Relay output lines, top to bottom
    typedef struct packed {
        logic       set_kb_block;
        logic       set_tab;
        logic       sync;                   // Print strobe
        logic [6:0] code;
    } consul_ctrl_t;

endpackage

/* consul_line_io.sv */
`timescale 1ns/100ps

module consul_line_io (
    input  logic                      Clk,
    input  logic                      Rst_n,
    input  logic [15:0]               regs_in,
    input  logic [6:0]                print_code,
    input  logic                      sync,
    input  logic                      kb_block,
    output consul_pkg::consul_status_t status,
    output logic                      kb_strobe,
    output logic [9:0]                regs_out
);

    consul_pkg::consul_status_t status_meta;   // First synchronizer stage
    consul_pkg::consul_ctrl_t   ctrl;
    logic                       cin_ready_q;   // Previous synchronized cin_ready

    // Two-stage synchronizer for the relay inputs
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            status_meta <= '0;
            status      <= '0;
            cin_ready_q <= 1'b0;
        end else begin
            status_meta <= regs_in;
            status      <= status_meta;
            cin_ready_q <= status.cin_ready;
        end
    end

    // One cycle pulse on the rise of keyboard ready
    assign kb_strobe = status.cin_ready & ~cin_ready_q;

    always_comb begin
        ctrl.set_kb_block = kb_block;
        ctrl.set_tab      = 1'b0;      // No tabulation
        ctrl.sync         = sync;
        ctrl.code         = print_code;
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            regs_out <= '0;
        end else begin
            regs_out <= ctrl;
        end
    end

endmodule

/* consul_print_seq.sv */
`timescale 1ns/100ps

module consul_print_seq (
    input  logic                      Clk,
    input  logic                      Rst_n,
    input  logic [7:0]                print_data_i,
    input  logic                      print_data_vld,
    output logic                      print_data_rdy,
    input  consul_pkg::consul_status_t status,
    output logic [6:0]                print_code,
    output logic                      sync
);

    logic [consul_pkg::SEQ_W-1:0] state;
    logic [6:0]                   char_q;      // Accepted character
    logic                         srv_q;       // Current code is a service code
    logic [consul_pkg::CNT_W-1:0] settle_cnt;

    // Choice made in the wait state
    logic [6:0]                   sel_code;
    logic [consul_pkg::CNT_W-1:0] sel_period;
    logic                         sel_srv;
    logic                         line_free;

    assign print_data_rdy = (state == consul_pkg::SEQ_IDLE);
    assign line_free      = ~status.is_moving & ~status.block_print;

    always_comb begin
        if (status.need_nl) begin
            sel_code   = consul_pkg::CODE_CR;
            sel_period = consul_pkg::PERIOD_NL[consul_pkg::CNT_W-1:0];
            sel_srv    = 1'b1;
        end else if (status.high_reg != char_q[5]) begin
            // Shift register must follow bit 5 of the character
            sel_code   = {consul_pkg::CODE_SHIFT_BASE, char_q[5]};
            sel_period = consul_pkg::PERIOD_COLOR[consul_pkg::CNT_W-1:0];
            sel_srv    = 1'b1;
        end else begin
            sel_code   = char_q;
            sel_period = consul_pkg::PERIOD_SYMBOL[consul_pkg::CNT_W-1:0];
            sel_srv    = 1'b0;
        end
    end

    // Character store, payload only
    always_ff @(posedge Clk) begin
        if (print_data_vld && print_data_rdy) begin
            char_q <= print_data_i[6:0];   // Bit 7 ignored
        end
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state      <= consul_pkg::SEQ_IDLE;
            srv_q      <= 1'b0;
            settle_cnt <= '0;
            print_code <= '0;
            sync       <= 1'b0;
        end else begin
            if (settle_cnt != '0) begin
                settle_cnt <= settle_cnt - 1'b1;
            end
            case (state)
                consul_pkg::SEQ_IDLE: begin
                    if (print_data_vld) begin
                        state <= consul_pkg::SEQ_WAIT;
                    end
                end
                consul_pkg::SEQ_WAIT: begin
                    if (line_free) begin
                        print_code <= sel_code;
                        settle_cnt <= sel_period;
                        srv_q      <= sel_srv;
                        state      <= consul_pkg::SEQ_SET_CODE;
                    end
                end
                consul_pkg::SEQ_SET_CODE: begin
                    sync  <= 1'b1;             // Code lines already stable
                    state <= consul_pkg::SEQ_HOLD_SYNC;
                end
                consul_pkg::SEQ_HOLD_SYNC: begin
                    if (settle_cnt == '0) begin
                        sync       <= 1'b0;
                        print_code <= '0;
                        // Service code done, still owe the character
                        state      <= srv_q ? consul_pkg::SEQ_WAIT : consul_pkg::SEQ_IDLE;
                    end
                end
                default: begin
                    state <= consul_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

/* consul_kb_receiver.sv */
`timescale 1ns/100ps

module consul_kb_receiver (
    input  logic                      Clk,
    input  logic                      Rst_n,
    input  consul_pkg::consul_status_t status,
    input  logic                      kb_strobe,
    output logic [7:0]                kb_data_o,
    output logic                      kb_data_vld,
    input  logic                      kb_data_rdy,
    output logic                      kb_block
);

    logic code_ok;   // Parity rule met
    logic accept;

    // Bit 7 set and odd parity over bits 6..0
    assign code_ok = status.kb_code[7] & (^status.kb_code[6:0]);

    // Strobes while a code is held are dropped
    assign accept = kb_strobe & code_ok & ~kb_data_vld;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            kb_data_o   <= '0;
            kb_data_vld <= 1'b0;
        end else begin
            if (accept) begin
                kb_data_o   <= status.kb_code;
                kb_data_vld <= 1'b1;
            end else if (kb_data_vld && kb_data_rdy) begin
                kb_data_vld <= 1'b0;     // Host took the code
            end
        end
    end

    // Keep the keyboard blocked while a code waits for the host
    assign kb_block = kb_data_vld;

endmodule

/* consul_top.sv */
`timescale 1ns/100ps

module consul_top (
    input  logic        Clk,
    input  logic        Rst_n,
    input  logic [15:0] regs_in,
    output logic [9:0]  regs_out,
    input  logic [7:0]  print_data_i,
    input  logic        print_data_vld,
    output logic        print_data_rdy,
    output logic [7:0]  kb_data_o,
    output logic        kb_data_vld,
    input  logic        kb_data_rdy
);

    consul_pkg::consul_status_t status;      // Synchronized relay inputs
    logic                       kb_strobe;
    logic [6:0]                 print_code;
    logic                       sync;
    logic                       kb_block;

    consul_line_io i_line_io (
        .Clk        (Clk),
        .Rst_n      (Rst_n),
        .regs_in    (regs_in),
        .print_code (print_code),
        .sync       (sync),
        .kb_block   (kb_block),
        .status     (status),
        .kb_strobe  (kb_strobe),
        .regs_out   (regs_out)
    );

    consul_print_seq i_print_seq (
        .Clk            (Clk),
        .Rst_n          (Rst_n),
        .print_data_i   (print_data_i),
        .print_data_vld (print_data_vld),
        .print_data_rdy (print_data_rdy),
        .status         (status),
        .print_code     (print_code),
        .sync           (sync)
    );

    consul_kb_receiver i_kb_receiver (
        .Clk         (Clk),
        .Rst_n       (Rst_n),
        .status      (status),
        .kb_strobe   (kb_strobe),
        .kb_data_o   (kb_data_o),
        .kb_data_vld (kb_data_vld),
        .kb_data_rdy (kb_data_rdy),
        .kb_block    (kb_block)
    );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
    output logic Clk,
    output logic Rst_n
);

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;     // 100 ns period
    end

    initial begin
        Rst_n = 1'b0;
        repeat (2) @(posedge Clk);
        #10 Rst_n = 1'b1;
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/100ps

module tb_checker (
    input logic       Clk,
    input logic       Rst_n,
    input logic [9:0] regs_out,
    input logic       print_data_rdy,
    input logic [7:0] kb_data_o,
    input logic       kb_data_vld,
    input logic       kb_data_rdy
);

    logic [6:0] exp_codes[$];
    logic [7:0] exp_keys[$];
    logic [6:0] exp_code;
    logic [7:0] exp_key;
    logic       sync_q;
    logic       quiet;          // No sync allowed while the line is blocked
    int         err_cnt = 0;
    int         test_err_start = 0;
    int         pass_cnt = 0;
    int         fail_cnt = 0;

    initial quiet = 1'b0;

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, act);
        err_cnt++;
    endtask

    task automatic fail_text(input string msg);
        $display("At %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_value(name, exp, act);
        end
    endtask

    task automatic push_code(input logic [6:0] code);
        exp_codes.push_back(code);
    endtask

    task automatic push_key(input logic [7:0] key);
        exp_keys.push_back(key);
    endtask

    task automatic set_quiet(input logic on);
        quiet = on;
    endtask

    task automatic begin_test();
        exp_codes.delete();
        exp_keys.delete();
        test_err_start = err_cnt;
    endtask

    task automatic end_test(input int idx);
        if (exp_codes.size() != 0) begin
            fail_text($sformatf("%0d expected print code(s) never appeared", exp_codes.size()));
        end
        if (exp_keys.size() != 0) begin
            fail_text("a valid key code never reached the host");
        end
        if (err_cnt == test_err_start) begin
            pass_cnt++;
            $display("Test %0d passed", idx);
        end else begin
            fail_cnt++;
            $display("Test %0d failed with %0d error(s)", idx, err_cnt - test_err_start);
        end
    endtask

    task automatic report();
        $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    endtask

    always @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            sync_q <= 1'b0;
        end else begin
            sync_q <= regs_out[7];
            check_value("regs_out.set_tab", 1'b0, regs_out[8]);   // Tabulation not used
            if (quiet) begin
                check_value("print_data_rdy", 1'b0, print_data_rdy);
            end
            if (regs_out[7] && !sync_q) begin   // Sync rise on the relay lines
                if (quiet) begin
                    fail_text("sync pulse while the carriage line was blocked");
                end else if (exp_codes.size() == 0) begin
                    fail_text($sformatf("unexpected sync pulse with code %0h", regs_out[6:0]));
                end else begin
                    exp_code = exp_codes.pop_front();
                    check_value("regs_out.code", exp_code, regs_out[6:0]);
                end
            end
            if (kb_data_vld && kb_data_rdy) begin  // Key transfer to host
                check_value("regs_out.set_kb_block", 1'b1, regs_out[9]);
                if (exp_keys.size() == 0) begin
                    fail_text($sformatf("unexpected key code %0h sent to host", kb_data_o));
                end else begin
                    exp_key = exp_keys.pop_front();
                    check_value("kb_data_o", exp_key, kb_data_o);
                end
            end
        end
    end

endmodule

/* tb_consul.sv */
`timescale 1ns/100ps

module tb_consul;

    typedef struct packed {
        logic [7:0] chr;
        logic       nl;          // Initial need_nl
        logic       hr;          // Initial high_reg
        logic [1:0] hold_kind;   // 0 none, 1 block_print, 2 is_moving
        logic [7:0] hold_cyc;
        logic       key_en;
        logic [7:0] key;
        logic       key_ok;
        logic [1:0] n_codes;
        logic [6:0] c0;
        logic [6:0] c1;
        logic [6:0] c2;
    } row_t;

    localparam int N_ROWS = 10;

    logic                       Clk;
    logic                       Rst_n;
    consul_pkg::consul_status_t lines;
    logic [15:0]                regs_in;
    logic [9:0]                 regs_out;
    logic [7:0]                 print_data_i;
    logic                       print_data_vld;
    logic                       print_data_rdy;
    logic [7:0]                 kb_data_o;
    logic                       kb_data_vld;
    logic                       kb_data_rdy;

    row_t       rows[N_ROWS];
    logic       sync_now;
    logic       sync_seen;
    logic [6:0] code_now;
    int         move_cnt;
    int         budget;

    assign regs_in = lines;

    tb_clk_gen i_clk_gen (.Clk(Clk), .Rst_n(Rst_n));

    consul_top i_consul_top (
        .Clk            (Clk),
        .Rst_n          (Rst_n),
        .regs_in        (regs_in),
        .regs_out       (regs_out),
        .print_data_i   (print_data_i),
        .print_data_vld (print_data_vld),
        .print_data_rdy (print_data_rdy),
        .kb_data_o      (kb_data_o),
        .kb_data_vld    (kb_data_vld),
        .kb_data_rdy    (kb_data_rdy)
    );

    tb_checker i_checker (
        .Clk            (Clk),
        .Rst_n          (Rst_n),
        .regs_out       (regs_out),
        .print_data_rdy (print_data_rdy),
        .kb_data_o      (kb_data_o),
        .kb_data_vld    (kb_data_vld),
        .kb_data_rdy    (kb_data_rdy)
    );

    task automatic next_cycle();
        @(posedge Clk);
        #10;
    endtask

    function automatic int settle_cycles(input logic [6:0] code);
        if (code == 7'h0D) begin
            return consul_pkg::PERIOD_NL;
        end else if (code[6:1] == 6'b000111) begin
            return consul_pkg::PERIOD_COLOR;
        end
        return consul_pkg::PERIOD_SYMBOL;
    endfunction

    task automatic build_table();
        // chr nl hr kind hold key_en key ok n c0 c1 c2
        rows[0] = '{8'h41, 0, 0, 0, 0, 0, 8'h00, 0, 1, 7'h41, 7'h00, 7'h00};
        rows[1] = '{8'h41, 0, 1, 0, 0, 0, 8'h00, 0, 2, 7'h0E, 7'h41, 7'h00};
        rows[2] = '{8'h61, 1, 0, 0, 0, 0, 8'h00, 0, 3, 7'h0D, 7'h0F, 7'h61};
        rows[3] = '{8'h22, 1, 1, 0, 0, 0, 8'h00, 0, 2, 7'h0D, 7'h22, 7'h00};
        rows[4] = '{8'h35, 0, 1, 1, 20, 0, 8'h00, 0, 1, 7'h35, 7'h00, 7'h00};
        rows[5] = '{8'h52, 0, 0, 2, 15, 0, 8'h00, 0, 1, 7'h52, 7'h00, 7'h00};
        rows[6] = '{8'h30, 0, 1, 0, 0, 1, 8'h81, 1, 1, 7'h30, 7'h00, 7'h00};
        rows[7] = '{8'h47, 0, 0, 0, 0, 1, 8'h83, 0, 1, 7'h47, 7'h00, 7'h00};
        rows[8] = '{8'h44, 0, 0, 0, 0, 1, 8'h07, 0, 1, 7'h44, 7'h00, 7'h00};
        rows[9] = '{8'hC1, 0, 1, 0, 0, 1, 8'hFF, 1, 2, 7'h0E, 7'h41, 7'h00};
    endtask

    task automatic run_row(input int idx);
        row_t r;
        logic got;
        r = rows[idx];
        i_checker.begin_test();
        lines.need_nl     = r.nl;
        lines.high_reg    = r.hr;
        lines.block_print = (r.hold_kind == 2'd1);
        lines.is_moving   = (r.hold_kind == 2'd2);
        repeat (4) next_cycle();
        i_checker.push_code(r.c0);
        if (r.n_codes > 1) i_checker.push_code(r.c1);
        if (r.n_codes > 2) i_checker.push_code(r.c2);
        if (r.key_en) begin
            if (r.key_ok) i_checker.push_key(r.key);
            lines.kb_code = r.key;
            next_cycle();
            lines.cin_ready = 1'b1;    // Key pressed
            repeat (3) next_cycle();
            lines.cin_ready = 1'b0;
        end
        print_data_i   = r.chr;
        print_data_vld = 1'b1;
        do begin
            got = print_data_rdy;
            next_cycle();
        end while (!got);
        print_data_vld = 1'b0;
        if (r.hold_kind != 2'd0) begin
            i_checker.set_quiet(1'b1);
            repeat (r.hold_cyc) next_cycle();
            i_checker.set_quiet(1'b0);
            lines.block_print = 1'b0;
            lines.is_moving   = 1'b0;
        end
        while (!print_data_rdy) next_cycle();
        repeat (8) next_cycle();
        while (kb_data_vld) next_cycle();
        repeat (6) next_cycle();
        i_checker.end_test(idx);
    endtask

    // Typewriter model moves the carriage while a code is struck
    always @(posedge Clk) begin
        sync_now = regs_out[7];
        code_now = regs_out[6:0];
        #10;
        if (sync_now && !sync_seen) begin
            lines.is_moving = 1'b1;
            if (code_now == 7'h0D) begin
                lines.need_nl = 1'b0;
            end else if (code_now[6:1] == 6'b000111) begin
                lines.high_reg = code_now[0];
            end
        end else if (!sync_now && sync_seen) begin
            move_cnt = 3;              // Carriage settles a few cycles
        end else if (move_cnt != 0) begin
            move_cnt--;
            if (move_cnt == 0) lines.is_moving = 1'b0;
        end
        sync_seen = sync_now;
    end

    // Host side of the keyboard stream with a random ready delay
    initial begin
        int d;
        kb_data_rdy = 1'b0;
        forever begin
            next_cycle();
            if (kb_data_vld) begin
                d = $urandom_range(4, 1);
                repeat (d) @(posedge Clk);
                #10 kb_data_rdy = 1'b1;
                next_cycle();
                kb_data_rdy = 1'b0;
            end
        end
    end

    initial begin
        #1;
        budget = 500;
        for (int i = 0; i < N_ROWS; i++) begin
            budget += settle_cycles(rows[i].c0) + settle_cycles(rows[i].c1);
            budget += settle_cycles(rows[i].c2) + rows[i].hold_cyc + 150;
        end
        #(budget * 100);
        $display("Watchdog expired after %0d cycles, the run did not complete", budget);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(88));
        lines          = '0;
        print_data_i   = '0;
        print_data_vld = 1'b0;
        sync_seen      = 1'b0;
        move_cnt       = 0;
        build_table();
        wait (Rst_n);
        next_cycle();
        i_checker.check_value("regs_out", 10'h000, regs_out);
        i_checker.check_value("kb_data_vld", 1'b0, kb_data_vld);
        i_checker.check_value("print_data_rdy", 1'b1, print_data_rdy);
        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        i_checker.report();
        if (i_checker.err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* list.f */
consul_pkg.sv
consul_line_io.sv
consul_print_seq.sv
consul_kb_receiver.sv
consul_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_consul.sv

/* Bender.yml */
package:
  name: consul

sources:
  - consul_pkg.sv
  - consul_line_io.sv
  - consul_print_seq.sv
  - consul_kb_receiver.sv
  - consul_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_checker.sv
      - tb_consul.sv
